/* include/fpu_macros.svh */
// Register count, tag codes, status-word bit positions and field constants for the FPU stack
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// ============================================================
// Register file size
// ============================================================
`define FPU_NUM_REGS 8

// ============================================================
// Tag codes, two bits per register
// ============================================================
`define FPU_TAG_VALID   2'b00
`define FPU_TAG_ZERO    2'b01
`define FPU_TAG_SPECIAL 2'b10
`define FPU_TAG_EMPTY   2'b11

// ============================================================
// Status word bit positions
// ============================================================
`define FPU_SW_IE      0
`define FPU_SW_SF      6
`define FPU_SW_ES      7
`define FPU_SW_C1      9
// TOP spans bits 13..11
`define FPU_SW_TOP_LSB 11

// ============================================================
// Extended real layout
// ============================================================
`define FPU_SIGN_BIT 79
`define FPU_EXP_MSB  78
`define FPU_EXP_LSB  64
`define FPU_EXP_MAX  15'h7FFF

`endif

/* hdl/fpu_pkg.sv */
// Package with FPU stack vector typedefs, opcode enum and controller state enum
`default_nettype none

package fpu_pkg;

    // 80-bit extended real: sign, 15-bit exponent, 64-bit significand
    typedef logic [79:0] ext_real_t;

    // ST(i) index or physical slot
    typedef logic [2:0] reg_idx_t;

    // Per-register tag
    typedef logic [1:0] tag_t;

    // Tag word in logical order, ST(0) in bits 1..0
    typedef logic [15:0] tag_word_t;

    typedef logic [15:0] status_word_t;

    // Operations accepted on the strobe interface
    typedef enum logic [3:0] {
        op_fld     = 4'd0,
        op_fst     = 4'd1,
        op_fstp    = 4'd2,
        op_fxch    = 4'd3,
        op_fchs    = 4'd4,
        op_fabs    = 4'd5,
        op_ffree   = 4'd6,
        op_fincstp = 4'd7,
        op_fdecstp = 4'd8,
        op_finit   = 4'd9,
        op_fclex   = 4'd10
    } fpu_op_t;

    // Sequencer, only FXCH needs a second cycle
    typedef enum logic {
        st_idle,
        st_xch_second
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/fpu_tag_classify.sv */
// Combinational tag classifier for an 80-bit extended real value
`default_nettype none

`include "fpu_macros.svh"

module fpu_tag_classify (
    input  fpu_pkg::ext_real_t value,
    output fpu_pkg::tag_t      tag
);

    logic [14:0] exponent;
    logic [63:0] significand;
    logic        exp_zero;
    logic        exp_max;
    logic        sig_zero;

    // Field split
    assign exponent    = value[`FPU_EXP_MSB:`FPU_EXP_LSB];
    assign significand = value[`FPU_EXP_LSB-1:0];

    assign exp_zero = (exponent == '0);
    assign exp_max  = (exponent == `FPU_EXP_MAX);
    assign sig_zero = (significand == '0);

    always_comb begin
        if (exp_zero && sig_zero) begin
            tag = `FPU_TAG_ZERO;
        end else if (exp_max || exp_zero) begin
            // Infinity, NaN, or denormal (zero exponent, nonzero significand)
            tag = `FPU_TAG_SPECIAL;
        end else begin
            tag = `FPU_TAG_VALID;
        end
    end

endmodule

`default_nettype wire

/* hdl/fpu_reg_stack.sv */
// Eight-register rotating FPU stack with tags, pointer, fault pulses and two relative read ports
`default_nettype none

`include "fpu_macros.svh"

module fpu_reg_stack (
    input  logic                  clk,
    input  logic                  reset,
    // Stack controls
    input  logic                  push,
    input  logic                  pop,
    input  logic                  inc_ptr,
    input  logic                  dec_ptr,
    input  logic                  free_reg,
    input  fpu_pkg::reg_idx_t     free_index,
    input  logic                  init_stack,
    // Write port, index relative to TOP
    input  logic                  write_enable,
    input  fpu_pkg::reg_idx_t     write_reg,
    input  fpu_pkg::ext_real_t    write_data,
    // Read selects, relative to TOP
    input  fpu_pkg::reg_idx_t     ctrl_read_sel,
    input  fpu_pkg::reg_idx_t     read_sel,
    output fpu_pkg::ext_real_t    st0,
    output fpu_pkg::ext_real_t    ctrl_read_data,
    output fpu_pkg::ext_real_t    read_data,
    // State
    output fpu_pkg::reg_idx_t     stack_ptr,
    output fpu_pkg::tag_word_t    tag_word,
    output logic                  stack_overflow,
    output logic                  stack_underflow
);

    import fpu_pkg::*;

    // ============================================================
    // Storage
    // ============================================================
    ext_real_t regs [`FPU_NUM_REGS];
    tag_t      tags [`FPU_NUM_REGS];

    reg_idx_t  next_ptr;
    reg_idx_t  write_base;
    reg_idx_t  write_slot;
    reg_idx_t  free_slot;
    reg_idx_t  ctrl_slot;
    reg_idx_t  read_slot;
    tag_t      write_tag;

    // Tag of incoming data
    fpu_tag_classify u_classify (
        .value (write_data),
        .tag   (write_tag)
    );

    // ============================================================
    // Pointer and slot mapping
    // ============================================================

    // Push and FDECSTP move TOP down, pop and FINCSTP move it up
    always_comb begin
        next_ptr = stack_ptr;
        if (push || dec_ptr) begin
            next_ptr = stack_ptr - 3'd1;
        end else if (pop || inc_ptr) begin
            next_ptr = stack_ptr + 3'd1;
        end
    end

    // Push+write lands relative to the new TOP
    // Pop+write and plain writes use the old TOP
    assign write_base = push ? next_ptr : stack_ptr;
    assign write_slot = write_base + write_reg;
    assign free_slot  = stack_ptr + free_index;
    assign ctrl_slot  = stack_ptr + ctrl_read_sel;
    assign read_slot  = stack_ptr + read_sel;

    // ============================================================
    // Tags, pointer and faults
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stack_ptr       <= '0;
            stack_overflow  <= 1'b0;
            stack_underflow <= 1'b0;
            for (int i = 0; i < `FPU_NUM_REGS; i++) begin
                tags[i] <= `FPU_TAG_EMPTY;
            end
        end else begin
            // Overflow when the new ST(0) slot is still occupied
            stack_overflow  <= push && (tags[next_ptr] != `FPU_TAG_EMPTY);
            // Underflow when popping an empty ST(0)
            stack_underflow <= pop && (tags[stack_ptr] == `FPU_TAG_EMPTY);

            stack_ptr <= init_stack ? reg_idx_t'(0) : next_ptr;

            if (init_stack) begin
                for (int i = 0; i < `FPU_NUM_REGS; i++) begin
                    tags[i] <= `FPU_TAG_EMPTY;
                end
            end
            if (free_reg) begin
                tags[free_slot] <= `FPU_TAG_EMPTY;
            end
            if (write_enable) begin
                tags[write_slot] <= write_tag;
            end
            // Pop last, so FSTP ST(0) leaves the slot empty
            if (pop) begin
                tags[stack_ptr] <= `FPU_TAG_EMPTY;
            end
        end
    end

    // Register payload, no reset
    always_ff @(posedge clk) begin
        if (write_enable) begin
            regs[write_slot] <= write_data;
        end
    end

    // ============================================================
    // Reads
    // ============================================================
    assign st0            = regs[stack_ptr];
    assign ctrl_read_data = regs[ctrl_slot];
    assign read_data      = regs[read_slot];

    // Tag word in logical order
    for (genvar g = 0; g < `FPU_NUM_REGS; g++) begin : g_tag_word
        assign tag_word[2*g +: 2] = tags[stack_ptr + reg_idx_t'(g)];
    end

endmodule

`default_nettype wire

/* hdl/fpu_stack_ctrl.sv */
// Opcode decoder and FXCH sequencer driving stack controls, busy and done
`default_nettype none

`include "fpu_macros.svh"

module fpu_stack_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    // Operation strobe
    input  logic                 op_valid,
    input  fpu_pkg::fpu_op_t     op,
    input  fpu_pkg::reg_idx_t    op_index,
    input  fpu_pkg::ext_real_t   op_data,
    // Stack reads
    input  fpu_pkg::ext_real_t   st0,
    input  fpu_pkg::ext_real_t   ctrl_read_data,
    // Stack controls
    output logic                 push,
    output logic                 pop,
    output logic                 inc_ptr,
    output logic                 dec_ptr,
    output logic                 free_reg,
    output fpu_pkg::reg_idx_t    free_index,
    output logic                 init_stack,
    output logic                 write_enable,
    output fpu_pkg::reg_idx_t    write_reg,
    output fpu_pkg::ext_real_t   write_data,
    output fpu_pkg::reg_idx_t    ctrl_read_sel,
    // Status and handshake
    output logic                 clear_exceptions,
    output logic                 busy,
    output logic                 done
);

    import fpu_pkg::*;

    ctrl_state_t state;
    ext_real_t   xch_latch;
    reg_idx_t    xch_index;
    logic        accept;
    logic        start_xch;

    // Strobes are only taken in idle
    assign accept    = op_valid && (state == st_idle);
    assign start_xch = accept && (op == op_fxch);
    assign busy      = (state == st_xch_second);

    // Both index ports follow the strobe directly
    assign free_index    = op_index;
    assign ctrl_read_sel = op_index;

    // ============================================================
    // Decode, controls valid in the strobe cycle
    // ============================================================
    always_comb begin
        push             = 1'b0;
        pop              = 1'b0;
        inc_ptr          = 1'b0;
        dec_ptr          = 1'b0;
        free_reg         = 1'b0;
        init_stack       = 1'b0;
        clear_exceptions = 1'b0;
        write_enable     = 1'b0;
        write_reg        = '0;
        write_data       = st0;

        if (busy) begin
            // FXCH second half, old ST(0) into ST(i)
            write_enable = 1'b1;
            write_reg    = xch_index;
            write_data   = xch_latch;
        end else if (accept) begin
            case (op)
                op_fld: begin
                    push         = 1'b1;
                    write_enable = 1'b1;
                    write_data   = op_data;
                end
                op_fst: begin
                    write_enable = 1'b1;
                    write_reg    = op_index;
                end
                op_fstp: begin
                    write_enable = 1'b1;
                    write_reg    = op_index;
                    pop          = 1'b1;
                end
                op_fxch: begin
                    // ST(i) into ST(0)
                    write_enable = 1'b1;
                    write_data   = ctrl_read_data;
                end
                op_fchs: begin
                    write_enable                = 1'b1;
                    write_data[`FPU_SIGN_BIT]   = ~st0[`FPU_SIGN_BIT];
                end
                op_fabs: begin
                    write_enable                = 1'b1;
                    write_data[`FPU_SIGN_BIT]   = 1'b0;
                end
                op_ffree:   free_reg = 1'b1;
                op_fincstp: inc_ptr  = 1'b1;
                op_fdecstp: dec_ptr  = 1'b1;
                op_finit: begin
                    init_stack       = 1'b1;
                    clear_exceptions = 1'b1;
                end
                op_fclex:   clear_exceptions = 1'b1;
                default: begin
                end
            endcase
        end
    end

    // ============================================================
    // Sequencer and done
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            state <= start_xch ? st_xch_second : st_idle;
            // One cycle after single-cycle ops, after the second FXCH write otherwise
            done  <= (accept && (op != op_fxch)) || busy;
        end
    end

    // Exchange payload
    always_ff @(posedge clk) begin
        if (start_xch) begin
            xch_latch <= st0;
            xch_index <= op_index;
        end
    end

endmodule

`default_nettype wire

/* hdl/fpu_status_word.sv */
// Sticky stack-fault flags and C1 merged with TOP into the 16-bit FPU status word
`default_nettype none

`include "fpu_macros.svh"

module fpu_status_word (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stack_overflow,
    input  logic                   stack_underflow,
    input  logic                   clear_exceptions,
    input  fpu_pkg::reg_idx_t      stack_ptr,
    output fpu_pkg::status_word_t  status_word
);

    // IE, SF and ES always move together for stack faults
    logic fault_q;
    logic c1_q;
    logic fault;

    assign fault = stack_overflow | stack_underflow;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fault_q <= 1'b0;
            c1_q    <= 1'b0;
        end else if (clear_exceptions) begin
            fault_q <= 1'b0;
            c1_q    <= 1'b0;
        end else if (fault) begin
            fault_q <= 1'b1;
            // C1 tells overflow from underflow
            c1_q    <= stack_overflow;
        end
    end

    // Fault pulse merged in so flags show in the done cycle
    always_comb begin
        status_word                                 = '0;
        status_word[`FPU_SW_IE]                     = fault_q | fault;
        status_word[`FPU_SW_SF]                     = fault_q | fault;
        status_word[`FPU_SW_ES]                     = fault_q | fault;
        status_word[`FPU_SW_C1]                     = fault ? stack_overflow : c1_q;
        status_word[`FPU_SW_TOP_LSB +: 3]           = stack_ptr;
    end

endmodule

`default_nettype wire

/* hdl/fpu_stack_unit.sv */
// Top level of the FPU register stack unit with controller, stack and status word
`default_nettype none

module fpu_stack_unit (
    input  logic                   clk,
    input  logic                   reset,
    // Operation strobe
    input  logic                   op_valid,
    input  fpu_pkg::fpu_op_t       op,
    input  fpu_pkg::reg_idx_t      op_index,
    input  fpu_pkg::ext_real_t     op_data,
    input  fpu_pkg::reg_idx_t      read_sel,
    // Results
    output logic                   busy,
    output logic                   done,
    output fpu_pkg::ext_real_t     st0,
    output fpu_pkg::ext_real_t     read_data,
    output fpu_pkg::tag_word_t     tag_word,
    output fpu_pkg::status_word_t  status_word
);

    import fpu_pkg::*;

    // Controller to stack
    logic      push;
    logic      pop;
    logic      inc_ptr;
    logic      dec_ptr;
    logic      free_reg;
    reg_idx_t  free_index;
    logic      init_stack;
    logic      write_enable;
    reg_idx_t  write_reg;
    ext_real_t write_data;
    reg_idx_t  ctrl_read_sel;
    ext_real_t ctrl_read_data;
    logic      clear_exceptions;

    // Stack to status
    reg_idx_t  stack_ptr;
    logic      stack_overflow;
    logic      stack_underflow;

    fpu_stack_ctrl u_ctrl (
        .clk              (clk),
        .reset            (reset),
        .op_valid         (op_valid),
        .op               (op),
        .op_index         (op_index),
        .op_data          (op_data),
        .st0              (st0),
        .ctrl_read_data   (ctrl_read_data),
        .push             (push),
        .pop              (pop),
        .inc_ptr          (inc_ptr),
        .dec_ptr          (dec_ptr),
        .free_reg         (free_reg),
        .free_index       (free_index),
        .init_stack       (init_stack),
        .write_enable     (write_enable),
        .write_reg        (write_reg),
        .write_data       (write_data),
        .ctrl_read_sel    (ctrl_read_sel),
        .clear_exceptions (clear_exceptions),
        .busy             (busy),
        .done             (done)
    );

    fpu_reg_stack u_stack (
        .clk             (clk),
        .reset           (reset),
        .push            (push),
        .pop             (pop),
        .inc_ptr         (inc_ptr),
        .dec_ptr         (dec_ptr),
        .free_reg        (free_reg),
        .free_index      (free_index),
        .init_stack      (init_stack),
        .write_enable    (write_enable),
        .write_reg       (write_reg),
        .write_data      (write_data),
        .ctrl_read_sel   (ctrl_read_sel),
        .read_sel        (read_sel),
        .st0             (st0),
        .ctrl_read_data  (ctrl_read_data),
        .read_data       (read_data),
        .stack_ptr       (stack_ptr),
        .tag_word        (tag_word),
        .stack_overflow  (stack_overflow),
        .stack_underflow (stack_underflow)
    );

    fpu_status_word u_status (
        .clk              (clk),
        .reset            (reset),
        .stack_overflow   (stack_overflow),
        .stack_underflow  (stack_underflow),
        .clear_exceptions (clear_exceptions),
        .stack_ptr        (stack_ptr),
        .status_word      (status_word)
    );

endmodule

`default_nettype wire

/* verification/tb_fpu_stack_unit.sv */
// Testbench for fpu_stack_unit with seeded random stimulus, stack model, checker and watchdog
`default_nettype none

`include "fpu_macros.svh"

module tb_fpu_stack_unit;

    import fpu_pkg::*;

    // ============================================================
    // Run length and time limit
    // ============================================================
    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 10;
    localparam int CYCLES_PER_OP = 10;
    // load/pop 16, faults 12, store/exchange 46, sign/rotate 30, random mix 201
    localparam int TOTAL_OPS     = 16 + 12 + 46 + 30 + 201;
    localparam int WATCHDOG_TIME = (TOTAL_OPS * CYCLES_PER_OP + RESET_CYCLES) * CLK_PERIOD;
    localparam int DONE_TIMEOUT  = 8;

    logic         clk;
    logic         reset;
    logic         op_valid;
    fpu_op_t      op;
    reg_idx_t     op_index;
    ext_real_t    op_data;
    reg_idx_t     read_sel;
    logic         busy;
    logic         done;
    ext_real_t    st0;
    ext_real_t    read_data;
    tag_word_t    tag_word;
    status_word_t status_word;

    // Behavioral model with physical slots addressed like the DUT
    ext_real_t    model_regs [8];
    tag_t         model_tags [8];
    logic         model_known [8];
    reg_idx_t     model_ptr;
    logic         model_fault;
    logic         model_c1;

    int           errors;
    int           checks;
    int           test_errors;

    fpu_stack_unit u_dut (
        .clk         (clk),
        .reset       (reset),
        .op_valid    (op_valid),
        .op          (op),
        .op_index    (op_index),
        .op_data     (op_data),
        .read_sel    (read_sel),
        .busy        (busy),
        .done        (done),
        .st0         (st0),
        .read_data   (read_data),
        .tag_word    (tag_word),
        .status_word (status_word)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Hard stop if the run stalls
    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d time units, the run did not complete",
                 WATCHDOG_TIME);
        $display("TB FAILED");
        $finish;
    end

    // ============================================================
    // Checker and reference functions
    // ============================================================
    task automatic check_value(input string name, input logic [79:0] got,
                               input logic [79:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // Zero, then all-ones exponent, then denormal, else normal
    function automatic tag_t expected_tag(input ext_real_t value);
        logic [14:0] e;
        logic [63:0] s;
        e = value[78:64];
        s = value[63:0];
        if (e == 15'd0 && s == 64'd0)
            return `FPU_TAG_ZERO;
        if (e == 15'h7FFF)
            return `FPU_TAG_SPECIAL;
        if (e == 15'd0)
            return `FPU_TAG_SPECIAL;
        return `FPU_TAG_VALID;
    endfunction

    function automatic tag_word_t expected_tag_word();
        tag_word_t tw;
        for (int i = 0; i < 8; i++) begin
            tw[2*i +: 2] = model_tags[model_ptr + 3'(i)];
        end
        return tw;
    endfunction

    function automatic status_word_t expected_status();
        status_word_t sw;
        sw = '0;
        sw[`FPU_SW_IE] = model_fault;
        sw[`FPU_SW_SF] = model_fault;
        sw[`FPU_SW_ES] = model_fault;
        sw[`FPU_SW_C1] = model_c1;
        sw[`FPU_SW_TOP_LSB +: 3] = model_ptr;
        return sw;
    endfunction

    // Biased toward zero, max exponent and denormal patterns
    function automatic ext_real_t rand_value();
        logic        sign;
        logic [14:0] e;
        logic [63:0] s;
        int          kind;
        kind = int'($urandom % 8);
        sign = 1'($urandom);
        e    = 15'($urandom);
        s    = {$urandom, $urandom};
        case (kind)
            0: begin
                e = 15'd0;
                s = 64'd0;
            end
            1: e = 15'h7FFF;
            2: begin
                e = 15'd0;
                if (s == 64'd0)
                    s = 64'd1;
            end
            default: begin
            end
        endcase
        return {sign, e, s};
    endfunction

    function automatic reg_idx_t rand_index();
        return reg_idx_t'($urandom % 8);
    endfunction

    // ============================================================
    // Model update for each accepted strobe
    // ============================================================
    task automatic model_apply(input fpu_op_t o, input reg_idx_t idx, input ext_real_t data);
        reg_idx_t  slot;
        reg_idx_t  np;
        ext_real_t a;
        logic      a_known;
        slot = model_ptr + idx;
        case (o)
            op_fld: begin
                np = model_ptr - 3'd1;
                if (model_tags[np] != `FPU_TAG_EMPTY) begin
                    model_fault = 1'b1;
                    model_c1    = 1'b1;
                end
                model_regs[np]  = data;
                model_tags[np]  = expected_tag(data);
                model_known[np] = 1'b1;
                model_ptr       = np;
            end
            op_fst, op_fstp: begin
                if (o == op_fstp && model_tags[model_ptr] == `FPU_TAG_EMPTY) begin
                    model_fault = 1'b1;
                    model_c1    = 1'b0;
                end
                model_regs[slot]  = model_regs[model_ptr];
                model_tags[slot]  = expected_tag(model_regs[model_ptr]);
                model_known[slot] = model_known[model_ptr];
                if (o == op_fstp) begin
                    model_tags[model_ptr] = `FPU_TAG_EMPTY;
                    model_ptr = model_ptr + 3'd1;
                end
            end
            op_fxch: begin
                a       = model_regs[model_ptr];
                a_known = model_known[model_ptr];
                model_regs[model_ptr]  = model_regs[slot];
                model_tags[model_ptr]  = expected_tag(model_regs[slot]);
                model_known[model_ptr] = model_known[slot];
                model_regs[slot]  = a;
                model_tags[slot]  = expected_tag(a);
                model_known[slot] = a_known;
            end
            op_fchs, op_fabs: begin
                // Sign bit only
                model_regs[model_ptr][79] = (o == op_fchs) ? ~model_regs[model_ptr][79] : 1'b0;
                model_tags[model_ptr] = expected_tag(model_regs[model_ptr]);
            end
            op_ffree:   model_tags[slot] = `FPU_TAG_EMPTY;
            op_fincstp: model_ptr = model_ptr + 3'd1;
            op_fdecstp: model_ptr = model_ptr - 3'd1;
            op_finit: begin
                for (int i = 0; i < 8; i++) begin
                    model_tags[i] = `FPU_TAG_EMPTY;
                end
                model_ptr   = 3'd0;
                model_fault = 1'b0;
                model_c1    = 1'b0;
            end
            op_fclex: begin
                model_fault = 1'b0;
                model_c1    = 1'b0;
            end
            default: begin
            end
        endcase
    endtask

    // ============================================================
    // Stimulus and response checks
    // ============================================================

    // Sampled at the falling edge of the done cycle
    task automatic check_state();
        reg_idx_t slot;
        slot = model_ptr + read_sel;
        if (model_known[model_ptr])
            check_value("st0", st0, model_regs[model_ptr]);
        check_value("tag_word", 80'(tag_word), 80'(expected_tag_word()));
        check_value("status_word", 80'(status_word), 80'(expected_status()));
        if (model_known[slot])
            check_value("read_data", read_data, model_regs[slot]);
    endtask

    // One strobe, wait for done, check latency and busy, then state
    task automatic run_op(input fpu_op_t o, input reg_idx_t idx, input ext_real_t data,
                          input reg_idx_t rsel);
        int   cycles;
        logic saw_busy;
        @(posedge clk);
        #1;
        op_valid = 1'b1;
        op       = o;
        op_index = idx;
        op_data  = data;
        read_sel = rsel;
        model_apply(o, idx, data);
        @(posedge clk);
        #1;
        op_valid = 1'b0;
        cycles   = 1;
        saw_busy = 1'b0;
        while (!done && cycles < DONE_TIMEOUT) begin
            saw_busy = saw_busy | busy;
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("done did not rise within %0d cycles of the %s strobe",
                     DONE_TIMEOUT, o.name());
        end else begin
            check_value("done_latency", 80'(cycles), (o == op_fxch) ? 80'd2 : 80'd1);
            check_value("busy_between", 80'(saw_busy), (o == op_fxch) ? 80'd1 : 80'd0);
            check_value("busy_at_done", 80'(busy), 80'd0);
        end
        @(negedge clk);
        check_state();
    endtask

    // Every relative read position against the model
    task automatic sweep_reads();
        reg_idx_t slot;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            read_sel = reg_idx_t'(i);
            @(negedge clk);
            slot = model_ptr + read_sel;
            if (model_known[slot])
                check_value("read_data", read_data, model_regs[slot]);
        end
    endtask

    task automatic start_test();
        test_errors = errors;
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_errors);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        fpu_op_t     o;
        void'($urandom(43));
        clk      = 1'b0;
        reset    = 1'b1;
        op_valid = 1'b0;
        op       = op_fld;
        op_index = '0;
        op_data  = '0;
        read_sel = '0;
        errors   = 0;
        checks   = 0;
        model_ptr   = '0;
        model_fault = 1'b0;
        model_c1    = 1'b0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i]  = '0;
            model_tags[i]  = `FPU_TAG_EMPTY;
            model_known[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // Load and pop with one value of each tag class first
        start_test();
        @(negedge clk);
        check_value("tag_word", 80'(tag_word), 80'hFFFF);
        check_value("status_word", 80'(status_word), 80'h0);
        run_op(op_fld, 3'd0, 80'h0, 3'd0);
        run_op(op_fld, 3'd0, {1'b0, 15'h7FFF, 64'h8000_0000_0000_0000}, 3'd0);
        run_op(op_fld, 3'd0, {1'b1, 15'h3FFF, 64'hC000_0000_0000_0000}, 3'd0);
        repeat (5) run_op(op_fld, 3'd0, rand_value(), rand_index());
        repeat (8) run_op(op_fstp, 3'd0, '0, rand_index());
        finish_test("load_pop");

        // Overflow on the ninth load and underflow on an empty pop
        start_test();
        repeat (9) run_op(op_fld, 3'd0, rand_value(), 3'd0);
        run_op(op_fclex, 3'd0, '0, 3'd0);
        run_op(op_finit, 3'd0, '0, 3'd0);
        run_op(op_fstp, 3'd0, '0, 3'd0);
        finish_test("stack_faults");

        // Store and exchange with full read sweeps
        start_test();
        repeat (6) run_op(op_fld, 3'd0, rand_value(), 3'd0);
        for (int n = 0; n < 40; n++) begin
            case ($urandom % 3)
                0: o = op_fst;
                1: o = op_fstp;
                default: o = op_fxch;
            endcase
            run_op(o, rand_index(), '0, 3'd0);
            sweep_reads();
        end
        finish_test("store_exchange");

        // Sign edits, free and pointer rotation
        start_test();
        run_op(op_finit, 3'd0, '0, 3'd0);
        repeat (5) run_op(op_fld, 3'd0, rand_value(), 3'd0);
        for (int n = 0; n < 24; n++) begin
            case ($urandom % 5)
                0: o = op_fchs;
                1: o = op_fabs;
                2: o = op_ffree;
                3: o = op_fincstp;
                default: o = op_fdecstp;
            endcase
            run_op(o, rand_index(), '0, 3'd0);
            sweep_reads();
        end
        finish_test("sign_free_rotate");

        // Mix of every opcode, then init
        start_test();
        for (int n = 0; n < 200; n++) begin
            o = fpu_op_t'(4'($urandom % 11));
            run_op(o, rand_index(), rand_value(), rand_index());
        end
        run_op(op_finit, 3'd0, '0, 3'd0);
        check_value("tag_word", 80'(tag_word), 80'hFFFF);
        check_value("status_word", 80'(status_word), 80'h0);
        finish_test("random_mix_init");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
hdl/fpu_pkg.sv
hdl/fpu_tag_classify.sv
hdl/fpu_reg_stack.sv
hdl/fpu_stack_ctrl.sv
hdl/fpu_status_word.sv
hdl/fpu_stack_unit.sv
verification/tb_fpu_stack_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the FPU stack testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_fpu_stack_unit \
    --Mdir obj_dir -o tb_fpu_stack_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_fpu_stack_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
